/* run_sim.sh */
#!/bin/sh
# builds the divider testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module tb_div_unit \
  -f sim.f \
  -o vsim \
  && ./obj_dir/vsim > sim.log 2>&1 \
  || { echo "build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log

grep -qx "all tests passed" sim.log \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL"; exit 1; }

/* sim.f */
verilog/div_pkg.sv
verilog/div_decode.sv
verilog/div_execute.sv
verilog/div_result.sv
verilog/div_unit.sv
verification/tb_div_unit.sv

/* verification/tb_div_unit.sv */
module tb_div_unit;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 200;  // longest operation needs 66 cycles

  logic              clk;
  logic              rst_n;
  logic              div_valid_i;
  div_pkg::div_req_t div_req_i;
  logic              result_ready_i;
  logic [63:0]       result_o;
  logic              result_ok_o;
  logic              div_busy_o;

  logic [31:0] seed;
  logic [63:0] exp_val;    // reference answer of the current request
  string       test_name;
  logic        check_en;
  logic        hold_en;
  logic        idle_en;
  int          errors;
  int          timeouts;

  div_unit i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .div_valid_i    (div_valid_i),
    .div_req_i      (div_req_i),
    .result_ready_i (result_ready_i),
    .result_o       (result_o),
    .result_ok_o    (result_ok_o),
    .div_busy_o     (div_busy_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ============================================================
  // checkers
  // ============================================================
  a_result: assert property (@(posedge clk) check_en |-> (result_o == exp_val))
    else begin
      errors = errors + 1;
      $display("error %s: expected %h, actual %h", test_name, exp_val, result_o);
    end

  // held result under back-pressure
  a_hold: assert property (@(posedge clk)
                           hold_en |-> (result_ok_o && div_busy_o && result_o == exp_val))
    else begin
      errors = errors + 1;
      $display("error %s: result not held, expected %h, actual %h ok %b busy %b",
               test_name, exp_val, result_o, result_ok_o, div_busy_o);
    end

  a_idle: assert property (@(posedge clk) idle_en |-> (!result_ok_o && !div_busy_o))
    else begin
      errors = errors + 1;
      $display("unit busy again after %s, the request sent while busy was accepted",
               test_name);
    end

  // ============================================================
  // reference model and random numbers
  // ============================================================
  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [63:0] rand64();
    logic [63:0] v;
    v[63:32] = lcg_next();
    v[31:0]  = lcg_next();
    return v;
  endfunction

  // random divisor of random magnitude
  function automatic logic [63:0] rand_divisor();
    logic [31:0] sh;
    sh = lcg_next();
    return rand64() >> sh[5:0];
  endfunction

  function automatic logic [63:0] ref_result(div_pkg::div_op_e op, logic [63:0] a,
                                             logic [63:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [31:0] swa;
    logic signed [31:0] swb;
    logic [31:0]        wa;
    logic [31:0]        wb;
    logic [31:0]        w;
    logic [63:0]        r;
    logic               word;
    sa   = a;
    sb   = b;
    wa   = a[31:0];
    wb   = b[31:0];
    swa  = wa;
    swb  = wb;
    r    = '0;
    w    = '0;
    word = 1'b0;
    case (op)
      div_pkg::DIVU: r = (b == '0) ? '1 : a / b;
      div_pkg::REMU: r = (b == '0) ? a : a % b;
      div_pkg::DIV: begin
        if (b == '0) r = '1;
        else if (a == 64'h8000_0000_0000_0000 && b == '1) r = a;
        else r = sa / sb;
      end
      div_pkg::REM: begin
        if (b == '0) r = a;
        else if (a == 64'h8000_0000_0000_0000 && b == '1) r = '0;
        else r = sa % sb;
      end
      div_pkg::DIVUW: begin
        word = 1'b1;
        w    = (wb == '0) ? '1 : wa / wb;
      end
      div_pkg::REMUW: begin
        word = 1'b1;
        w    = (wb == '0) ? wa : wa % wb;
      end
      div_pkg::DIVW: begin
        word = 1'b1;
        if (wb == '0) w = '1;
        else if (wa == 32'h8000_0000 && wb == '1) w = wa;
        else w = swa / swb;
      end
      default: begin  // remw
        word = 1'b1;
        if (wb == '0) w = wa;
        else if (wa == 32'h8000_0000 && wb == '1) w = '0;
        else w = swa % swb;
      end
    endcase
    if (word) r = {{32{w[31]}}, w};
    return r;
  endfunction

  // ============================================================
  // stimulus tasks
  // ============================================================
  task automatic start_op(input string name, input div_pkg::div_op_e op,
                          input logic [63:0] a, input logic [63:0] b);
    @(negedge clk);
    test_name          = name;
    exp_val            = ref_result(op, a, b);
    div_req_i.op       = op;
    div_req_i.dividend = a;
    div_req_i.divisor  = b;
    div_valid_i        = 1'b1;
    @(negedge clk);
    div_valid_i = 1'b0;
  endtask

  task automatic wait_result(output logic got);
    int n;
    n = 0;
    while (!result_ok_o && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    got = result_ok_o;
    if (!got) begin
      timeouts++;
      $display("no result arrived for %s within %0d cycles", test_name, TIMEOUT);
    end
  endtask

  task automatic check_result();
    check_en = 1'b1;
    @(negedge clk);
    check_en = 1'b0;
  endtask

  task automatic release_result();
    int n;
    result_ready_i = 1'b1;
    @(negedge clk);
    result_ready_i = 1'b0;
    n = 0;
    while (div_busy_o && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (div_busy_o) begin
      timeouts++;
      $display("busy did not fall after %s was taken", test_name);
    end
  endtask

  task automatic do_op(input string name, input div_pkg::div_op_e op,
                       input logic [63:0] a, input logic [63:0] b);
    logic got;
    start_op(name, op, a, b);
    wait_result(got);
    if (got) begin
      check_result();
      release_result();
    end
  endtask

  // result held with ready low while an extra request is dropped
  task automatic backpressure_test();
    logic got;
    start_op("bp_div", div_pkg::DIV, -64'sd1000, 64'd7);
    wait_result(got);
    if (got) begin
      hold_en = 1'b1;
      repeat (3) @(negedge clk);
      div_req_i.op       = div_pkg::DIVU;
      div_req_i.dividend = 64'd100;
      div_req_i.divisor  = 64'd3;
      div_valid_i        = 1'b1;
      @(negedge clk);
      div_valid_i = 1'b0;
      repeat (4) @(negedge clk);
      hold_en = 1'b0;
      check_result();
      release_result();
      idle_en = 1'b1;
      repeat (5) @(negedge clk);
      idle_en = 1'b0;
    end
  endtask

  // ============================================================
  // main sequence
  // ============================================================
  initial begin
    logic [63:0] a;
    logic [63:0] b;
    logic [31:0] t;
    seed           = 32'h3aba_cf39;
    errors         = 0;
    timeouts       = 0;
    check_en       = 1'b0;
    hold_en        = 1'b0;
    idle_en        = 1'b0;
    test_name      = "reset";
    exp_val        = '0;
    div_valid_i    = 1'b0;
    div_req_i      = '0;
    result_ready_i = 1'b0;
    rst_n          = 1'b1;  // reset is active high
    repeat (2) @(negedge clk);
    rst_n = 1'b0;

    for (int i = 0; i < 16; i++) begin
      a = rand64();
      b = rand_divisor();
      do_op($sformatf("divu_%0d", i), div_pkg::DIVU, a, b);
      do_op($sformatf("remu_%0d", i), div_pkg::REMU, a, b);
    end
    for (int i = 0; i < 16; i++) begin
      a = rand64();
      b = rand_divisor();
      if (a[7]) b = -b;  // either divisor sign
      do_op($sformatf("div_%0d", i), div_pkg::DIV, a, b);
      do_op($sformatf("rem_%0d", i), div_pkg::REM, a, b);
    end
    // small mixed signs where the remainder follows the dividend
    do_op("div_neg_pos", div_pkg::DIV, -64'sd7, 64'd2);
    do_op("rem_neg_pos", div_pkg::REM, -64'sd7, 64'd2);
    do_op("rem_pos_neg", div_pkg::REM, 64'd7, -64'sd2);
    do_op("rem_neg_neg", div_pkg::REM, -64'sd7, -64'sd2);

    // upper operand bits are junk for word ops
    for (int i = 0; i < 10; i++) begin
      a = rand64();
      t = lcg_next();
      b = rand_divisor() | {32'h0, 16'h0, t[15:8], 8'h0};
      do_op($sformatf("divw_%0d", i), div_pkg::DIVW, a, b);
      do_op($sformatf("divuw_%0d", i), div_pkg::DIVUW, a, b);
      do_op($sformatf("remw_%0d", i), div_pkg::REMW, a, b);
      do_op($sformatf("remuw_%0d", i), div_pkg::REMUW, a, b);
    end

    a = rand64();
    do_op("div_zero", div_pkg::DIV, a, 64'd0);
    do_op("divu_zero", div_pkg::DIVU, a, 64'd0);
    do_op("rem_zero", div_pkg::REM, a, 64'd0);
    do_op("remu_zero", div_pkg::REMU, a, 64'd0);
    do_op("divw_zero", div_pkg::DIVW, a, 64'hdead_beef_0000_0000);
    do_op("divuw_zero", div_pkg::DIVUW, a, 64'hdead_beef_0000_0000);
    do_op("remw_zero", div_pkg::REMW, a, 64'hdead_beef_0000_0000);
    do_op("remuw_zero", div_pkg::REMUW, a, 64'hdead_beef_0000_0000);

    do_op("div_ovf", div_pkg::DIV, 64'h8000_0000_0000_0000, '1);
    do_op("rem_ovf", div_pkg::REM, 64'h8000_0000_0000_0000, '1);
    do_op("divw_ovf", div_pkg::DIVW, 64'h1234_5678_8000_0000, 64'h0000_0000_ffff_ffff);
    do_op("remw_ovf", div_pkg::REMW, 64'h1234_5678_8000_0000, 64'h0000_0000_ffff_ffff);

    backpressure_test();

    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* verilog/div_decode.sv */
module div_decode (
  input  div_pkg::div_req_t  div_req_i,
  output div_pkg::div_prep_t prep_o
);

  logic                     is_signed;
  logic                     is_word;
  logic                     is_rem;
  logic [div_pkg::XLEN-1:0] a_ext;      // dividend at operation width
  logic [div_pkg::XLEN-1:0] b_ext;      // divisor at operation width
  logic                     a_neg;
  logic                     b_neg;
  logic [div_pkg::XLEN-1:0] a_abs;
  logic [div_pkg::XLEN-1:0] b_abs;
  logic                     div_zero;
  logic                     div_ovf;
  logic [div_pkg::XLEN-1:0] min_val;

  // ============================================================
  // operation class
  // ============================================================
  always_comb begin
    is_signed = 1'b0;
    is_word   = 1'b0;
    is_rem    = 1'b0;
    case (div_req_i.op)
      div_pkg::DIV: begin
        is_signed = 1'b1;
      end
      div_pkg::DIVU: begin
        is_signed = 1'b0;
      end
      div_pkg::DIVUW: begin
        is_word = 1'b1;
      end
      div_pkg::DIVW: begin
        is_signed = 1'b1;
        is_word   = 1'b1;
      end
      div_pkg::REM: begin
        is_signed = 1'b1;
        is_rem    = 1'b1;
      end
      div_pkg::REMU: begin
        is_rem = 1'b1;
      end
      div_pkg::REMUW: begin
        is_word = 1'b1;
        is_rem  = 1'b1;
      end
      div_pkg::REMW: begin
        is_signed = 1'b1;
        is_word   = 1'b1;
        is_rem    = 1'b1;
      end
      default: begin
        is_signed = 1'b0;  // unknown code runs as divu
      end
    endcase
  end

  // word operands are sign or zero extended from bit 31
  always_comb begin
    a_ext = div_req_i.dividend;
    b_ext = div_req_i.divisor;
    if (is_word) begin
      a_ext = {{div_pkg::EXT_W{is_signed & div_req_i.dividend[div_pkg::WLEN-1]}},
               div_req_i.dividend[div_pkg::WLEN-1:0]};
      b_ext = {{div_pkg::EXT_W{is_signed & div_req_i.divisor[div_pkg::WLEN-1]}},
               div_req_i.divisor[div_pkg::WLEN-1:0]};
    end
  end

  assign a_neg = is_signed & a_ext[div_pkg::XLEN-1];
  assign b_neg = is_signed & b_ext[div_pkg::XLEN-1];
  assign a_abs = a_neg ? -a_ext : a_ext;
  assign b_abs = b_neg ? -b_ext : b_ext;

  // ============================================================
  // special cases
  // ============================================================
  assign min_val  = is_word ? div_pkg::MIN_W : div_pkg::MIN_X;
  assign div_zero = ~|b_ext;
  assign div_ovf  = is_signed & (a_ext == min_val) & (&b_ext);

  always_comb begin
    prep_o.ctrl.is_word = is_word;
    prep_o.ctrl.is_rem  = is_rem;
    prep_o.ctrl.special = div_zero | div_ovf;
    prep_o.ctrl.neg_q   = ~(div_zero | div_ovf) & (a_neg ^ b_neg);
    prep_o.ctrl.neg_r   = ~(div_zero | div_ovf) & a_neg;
    // word dividend sits in the upper half, so 32 steps finish it
    prep_o.dividend_mag = is_word ? {a_abs[div_pkg::WLEN-1:0], {div_pkg::WLEN{1'b0}}} : a_abs;
    prep_o.divisor_mag  = b_abs;
    if (div_zero) begin
      prep_o.spec_q = '1;     // all ones
      prep_o.spec_r = a_ext;
    end else begin
      prep_o.spec_q = a_ext;  // overflow, or unused
      prep_o.spec_r = '0;
    end
  end

endmodule

/* verilog/div_execute.sv */
module div_execute (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               div_valid_i,
  input  div_pkg::div_prep_t prep_i,
  input  logic               release_i,
  output div_pkg::div_core_t core_o,
  output logic               core_done_o,
  output logic               busy_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_HOLD
  } state_e;

  state_e                     state_q;
  logic [div_pkg::CNT_W-1:0]  cnt_q;      // steps left
  div_pkg::div_ctrl_t         ctrl_q;
  logic                       done_q;
  logic [2*div_pkg::XLEN-1:0] rq_q;       // {remainder, quotient}
  logic [div_pkg::XLEN-1:0]   divisor_q;
  logic [div_pkg::XLEN:0]     partial;    // shifted remainder, 65 bits
  logic [div_pkg::XLEN+1:0]   diff;
  logic                       borrow;
  logic [div_pkg::XLEN-1:0]   rem_next;
  logic                       accept;

  assign accept = div_valid_i & (state_q == ST_IDLE);

  // ============================================================
  // one restoring step
  // ============================================================
  // keep the bit shifted out of the top, divisors above 2^63 need it
  assign partial  = rq_q[2*div_pkg::XLEN-1:div_pkg::XLEN-1];
  assign diff     = {1'b0, partial} - {2'b00, divisor_q};
  assign borrow   = diff[div_pkg::XLEN+1];
  assign rem_next = borrow ? partial[div_pkg::XLEN-1:0] : diff[div_pkg::XLEN-1:0];

  // ============================================================
  // control
  // ============================================================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
      ctrl_q  <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;  // single cycle pulse
      case (state_q)
        ST_IDLE: begin
          if (accept) begin
            ctrl_q <= prep_i.ctrl;
            if (prep_i.ctrl.special) begin
              state_q <= ST_HOLD;
              done_q  <= 1'b1;
            end else begin
              state_q <= ST_RUN;
              cnt_q   <= prep_i.ctrl.is_word ? div_pkg::STEPS_W : div_pkg::STEPS_X;
            end
          end
        end
        ST_RUN: begin
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == 1) begin  // last step
            state_q <= ST_HOLD;
            done_q  <= 1'b1;
          end
        end
        ST_HOLD: begin
          if (release_i) state_q <= ST_IDLE;  // result taken
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // datapath
  always_ff @(posedge clk) begin
    if (accept) begin
      divisor_q <= prep_i.divisor_mag;
      if (prep_i.ctrl.special) rq_q <= {prep_i.spec_r, prep_i.spec_q};
      else                     rq_q <= {{div_pkg::XLEN{1'b0}}, prep_i.dividend_mag};
    end else if (state_q == ST_RUN) begin
      rq_q <= {rem_next, rq_q[div_pkg::XLEN-2:0], ~borrow};  // shift in quotient bit
    end
  end

  assign core_o.quot  = rq_q[div_pkg::XLEN-1:0];
  assign core_o.rem   = rq_q[2*div_pkg::XLEN-1:div_pkg::XLEN];
  assign core_o.ctrl  = ctrl_q;
  assign core_done_o  = done_q;
  assign busy_o       = (state_q != ST_IDLE);

endmodule

/* verilog/div_pkg.sv */
package div_pkg;

  // ============================================================
  // widths
  // ============================================================
  localparam int XLEN  = 64;
  localparam int WLEN  = 32;
  localparam int CNT_W = 7;                  // must hold XLEN
  localparam int EXT_W = XLEN - WLEN;        // sign extension width for word results

  // step counts loaded at the start of an iteration
  localparam logic [CNT_W-1:0] STEPS_X = 7'd64;
  localparam logic [CNT_W-1:0] STEPS_W = 7'd32;

  // most negative operands, after word sign extension
  localparam logic [XLEN-1:0] MIN_X = {1'b1, {(XLEN-1){1'b0}}};
  localparam logic [XLEN-1:0] MIN_W = {{(EXT_W+1){1'b1}}, {(WLEN-1){1'b0}}};

  // ============================================================
  // operation encoding, one-hot
  // ============================================================
  typedef enum logic [7:0] {
    DIV   = 8'b1000_0000,  // signed, 64 bit
    DIVU  = 8'b0100_0000,  // unsigned, 64 bit
    DIVUW = 8'b0010_0000,  // unsigned, 32 bit
    DIVW  = 8'b0001_0000,  // signed, 32 bit
    REM   = 8'b0000_1000,
    REMU  = 8'b0000_0100,
    REMUW = 8'b0000_0010,
    REMW  = 8'b0000_0001
  } div_op_e;

  // ============================================================
  // structs between blocks
  // ============================================================
  typedef struct packed {
    div_op_e         op;
    logic [XLEN-1:0] dividend;
    logic [XLEN-1:0] divisor;
  } div_req_t;

  typedef struct packed {
    logic is_word;  // low 32 bits only
    logic is_rem;   // remainder wanted, not quotient
    logic neg_q;
    logic neg_r;
    logic special;  // answer fixed at decode
  } div_ctrl_t;

  typedef struct packed {
    div_ctrl_t       ctrl;
    logic [XLEN-1:0] dividend_mag;
    logic [XLEN-1:0] divisor_mag;
    logic [XLEN-1:0] spec_q;
    logic [XLEN-1:0] spec_r;
  } div_prep_t;

  typedef struct packed {
    logic [XLEN-1:0] quot;  // unsigned magnitude
    logic [XLEN-1:0] rem;   // unsigned magnitude
    div_ctrl_t       ctrl;
  } div_core_t;

endpackage

/* verilog/div_result.sv */
module div_result (
  input  logic                     clk,
  input  logic                     rst_n,
  input  div_pkg::div_core_t       core_i,
  input  logic                     core_done_i,
  input  logic                     result_ready_i,
  output logic [div_pkg::XLEN-1:0] result_o,
  output logic                     result_ok_o,
  output logic                     release_o
);

  logic [div_pkg::XLEN-1:0] sel;
  logic                     neg;
  logic [div_pkg::XLEN-1:0] signed_val;
  logic [div_pkg::XLEN-1:0] final_val;
  logic [div_pkg::XLEN-1:0] result_q;
  logic                     ok_q;
  logic                     release_q;

  // ============================================================
  // final value
  // ============================================================
  assign sel        = core_i.ctrl.is_rem ? core_i.rem : core_i.quot;
  assign neg        = core_i.ctrl.is_rem ? core_i.ctrl.neg_r : core_i.ctrl.neg_q;
  assign signed_val = neg ? -sel : sel;

  // word results are the sign extension of bit 31
  assign final_val = core_i.ctrl.is_word ?
                     {{div_pkg::EXT_W{signed_val[div_pkg::WLEN-1]}},
                      signed_val[div_pkg::WLEN-1:0]} :
                     signed_val;

  // ============================================================
  // held result and handshake
  // ============================================================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      result_q  <= '0;
      ok_q      <= 1'b0;
      release_q <= 1'b0;
    end else begin
      release_q <= 1'b0;
      if (core_done_i) begin
        result_q <= final_val;
        ok_q     <= 1'b1;
      end else if (ok_q && result_ready_i) begin
        ok_q      <= 1'b0;  // consumer took it
        release_q <= 1'b1;  // frees the execute stage
      end
    end
  end

  assign result_o    = result_q;
  assign result_ok_o = ok_q;
  assign release_o   = release_q;

endmodule

/* verilog/div_unit.sv */
module div_unit (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     div_valid_i,
  input  div_pkg::div_req_t        div_req_i,
  input  logic                     result_ready_i,
  output logic [div_pkg::XLEN-1:0] result_o,
  output logic                     result_ok_o,
  output logic                     div_busy_o
);

  div_pkg::div_prep_t prep;
  div_pkg::div_core_t core;
  logic               core_done;
  logic               release_pulse;  // result taken, execute may go idle

  // ============================================================
  // operand preparation
  // ============================================================
  div_decode i_decode (
    .div_req_i (div_req_i),
    .prep_o    (prep)
  );

  // ============================================================
  // iteration
  // ============================================================
  div_execute i_execute (
    .clk         (clk),
    .rst_n       (rst_n),
    .div_valid_i (div_valid_i),
    .prep_i      (prep),
    .release_i   (release_pulse),
    .core_o      (core),
    .core_done_o (core_done),
    .busy_o      (div_busy_o)
  );

  // sign fix and output hold
  div_result i_result (
    .clk            (clk),
    .rst_n          (rst_n),
    .core_i         (core),
    .core_done_i    (core_done),
    .result_ready_i (result_ready_i),
    .result_o       (result_o),
    .result_ok_o    (result_ok_o),
    .release_o      (release_pulse)
  );

endmodule
